// ==== source/mc_defines.svh ====
// Motor controller board parameters
// Channel count, field widths, watchdog time base and register map
`ifndef MC_DEFINES_SVH
`define MC_DEFINES_SVH

// Board sizing
`define MC_NUM_MOTORS     4       // Motor channels, numbered 1..N on the bus
`define MC_DAC_WIDTH      16      // Setpoint bits
`define MC_ENC_WIDTH      24      // Encoder count bits, two's complement
`define MC_WDOG_TICK_DIV  8       // sysclk cycles per watchdog tick

// Address: [7:4] channel, [3:0] register
// Channel 0 is the board channel
`define MC_REG_STATUS       4'd0  // Board id, timeout flag, channel count
`define MC_REG_WDOG_PERIOD  4'd1  // Watchdog period in ticks, 0 disables
`define MC_REG_AMP_EN       4'd2  // Amplifier enable mask

// Motor channels 1..N
`define MC_REG_DAC          4'd0  // Setpoint
`define MC_REG_ENC          4'd1  // Encoder count, write presets

`endif

// ==== source/mc_pkg.sv ====
// Shared types for the motor controller board
// Bus words, motor fields and the APB bridge state
`include "mc_defines.svh"

package mc_pkg;

    // Register bus words
    typedef logic [15:0] reg_addr_t;
    typedef logic [31:0] reg_data_t;

    // Motor channel fields
    typedef logic [`MC_DAC_WIDTH-1:0] dac_t;        // Setpoint to the DAC
    typedef logic [`MC_ENC_WIDTH-1:0] enc_count_t;  // Signed position count

    // Board level fields
    typedef logic [15:0] wdog_period_t;              // Ticks before timeout
    typedef logic [3:0]  board_id_t;                 // Rotary switch value
    typedef logic [`MC_NUM_MOTORS-1:0] amp_mask_t;   // One bit per motor

    // APB bridge FSM
    // idle covers setup and write access
    // read_wait is the single read wait state
    typedef enum logic {
        idle,
        read_wait
    } apb_state_t;

endpackage

// ==== source/reg_bus_if.sv ====
// Internal register read/write bus
// Plain address, data and write enable between bridge and board block
`timescale 1ns/1ps

interface reg_bus_if;

    mc_pkg::reg_addr_t raddr;   // Read address, rdata follows a cycle later
    mc_pkg::reg_addr_t waddr;   // Write address
    mc_pkg::reg_data_t wdata;   // Write data
    logic              wen;     // Write strobe, one cycle per write
    mc_pkg::reg_data_t rdata;   // Registered read data

    // Bridge side
    modport master (
        output raddr,
        output waddr,
        output wdata,
        output wen,
        input  rdata
    );

    // Register block side
    modport target (
        input  raddr,
        input  waddr,
        input  wdata,
        input  wen,
        output rdata
    );

endinterface

// ==== source/apb_reg_bridge.sv ====
// APB slave to register bus bridge
// Writes complete with no wait state, reads take one wait state
`timescale 1ns/1ps

module apb_reg_bridge (
    input  logic              sysclk,
    input  logic              rst_n,
    input  logic              psel,
    input  logic              penable,
    input  logic              pwrite,
    input  mc_pkg::reg_addr_t paddr,
    input  mc_pkg::reg_data_t pwdata,
    output mc_pkg::reg_data_t prdata,
    output logic              pready,
    output logic              pslverr,
    reg_bus_if.master         bus
);

    mc_pkg::apb_state_t state;
    mc_pkg::apb_state_t state_next;
    logic               wr_access;      // Write access phase
    logic               rd_access;      // Read access phase

    assign wr_access = psel & penable & pwrite;
    assign rd_access = psel & penable & ~pwrite;

    // First read access cycle waits for rdata
    always_comb begin
        state_next = state;
        case (state)
            mc_pkg::idle:      if (rd_access) state_next = mc_pkg::read_wait;
            mc_pkg::read_wait: state_next = mc_pkg::idle;   // Read completes here
            default:           state_next = mc_pkg::idle;
        endcase
    end

    always_ff @(posedge sysclk or negedge rst_n) begin
        if (!rst_n) begin
            state <= mc_pkg::idle;
        end else begin
            state <= state_next;
        end
    end

    // Address valid from setup on, so rdata is ready by the second access cycle
    assign bus.raddr = paddr;
    assign bus.waddr = paddr;
    assign bus.wdata = pwdata;
    assign bus.wen   = wr_access & (state == mc_pkg::idle);   // One pulse per write

    // Write ends in the first access cycle, read in the second
    assign pready  = bus.wen | (rd_access & (state == mc_pkg::read_wait));
    assign prdata  = bus.rdata;     // Already registered in the board block
    assign pslverr = 1'b0;          // Every address answers

endmodule

// ==== source/tick_gen.sv ====
// Watchdog time base
// One-cycle enable every MC_WDOG_TICK_DIV sysclk cycles
`timescale 1ns/1ps
`include "mc_defines.svh"

module tick_gen (
    input  logic sysclk,
    input  logic rst_n,
    output logic tick
);

    localparam int CNT_W = $clog2(`MC_WDOG_TICK_DIV);
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(`MC_WDOG_TICK_DIV - 1);

    logic [CNT_W-1:0] div_cnt;     // Position within the tick period

    // Enable instead of a divided clock, all logic stays on sysclk
    always_ff @(posedge sysclk or negedge rst_n) begin
        if (!rst_n) begin
            div_cnt <= '0;
            tick    <= 1'b0;
        end else begin
            tick <= (div_cnt == CNT_LAST);          // High for one cycle
            if (div_cnt == CNT_LAST) begin
                div_cnt <= '0;                       // Wrap
            end else begin
                div_cnt <= div_cnt + 1'b1;
            end
        end
    end

endmodule

// ==== source/quad_encoder.sv ====
// Quadrature encoder channel
// Two-stage input sync, 4x decode and presettable up/down count
`timescale 1ns/1ps

module quad_encoder (
    input  logic               sysclk,
    input  logic               rst_n,
    input  logic               enc_a,
    input  logic               enc_b,
    input  logic               preset_en,
    input  mc_pkg::enc_count_t preset_val,
    output mc_pkg::enc_count_t count
);

    logic [1:0] a_sync;     // [0] first stage, [1] second stage
    logic [1:0] b_sync;
    logic [1:0] cur_ab;     // {a, b} after sync
    logic [1:0] prev_ab;    // {a, b} one cycle earlier
    logic       step_up;
    logic       step_dn;

    assign cur_ab = {a_sync[1], b_sync[1]};

    // Forward runs 00 -> 10 -> 11 -> 01, A leads B
    // No change or a double change matches neither
    assign step_up = (cur_ab == {~prev_ab[0], prev_ab[1]});
    assign step_dn = (cur_ab == {prev_ab[0], ~prev_ab[1]});

    always_ff @(posedge sysclk or negedge rst_n) begin
        if (!rst_n) begin
            a_sync  <= 2'b00;
            b_sync  <= 2'b00;
            prev_ab <= 2'b00;
            count   <= '0;
        end else begin
            a_sync  <= {a_sync[0], enc_a};   // Async phase inputs
            b_sync  <= {b_sync[0], enc_b};
            prev_ab <= cur_ab;
            if (preset_en) begin
                count <= preset_val;         // Host preset wins over decode
            end else if (step_up) begin
                count <= count + 1'b1;
            end else if (step_dn) begin
                count <= count - 1'b1;       // Wraps through two's complement
            end
        end
    end

endmodule

// ==== source/motor_wdog.sv ====
// Host activity watchdog
// Counts ticks since the last host write and latches a timeout
`timescale 1ns/1ps

module motor_wdog (
    input  logic                 sysclk,
    input  logic                 rst_n,
    input  logic                 tick,
    input  logic                 host_write,
    input  mc_pkg::wdog_period_t period,
    input  logic                 clear,
    output logic                 timeout
);

    mc_pkg::wdog_period_t tick_cnt;   // Ticks since last host write
    logic                 wdog_on;    // Period of zero disables
    logic                 reached;

    assign wdog_on = (period != '0);

    // >= so a period lowered below the running count still trips
    assign reached = wdog_on && (tick_cnt >= period);

    always_ff @(posedge sysclk or negedge rst_n) begin
        if (!rst_n) begin
            tick_cnt <= '0;
            timeout  <= 1'b0;
        end else begin
            if (clear || host_write) begin
                tick_cnt <= '0;                   // Any host write restarts
            end else if (tick && wdog_on && !reached) begin
                tick_cnt <= tick_cnt + 1'b1;      // Stops once the period is hit
            end

            // Sticky until the host clears it
            if (clear) begin
                timeout <= 1'b0;
            end else if (reached) begin
                timeout <= 1'b1;
            end
        end
    end

endmodule

// ==== source/motor_ctrl_board.sv ====
// Motor controller board registers
// Setpoints, amplifier enables, status, encoders and the host watchdog
`timescale 1ns/1ps
`include "mc_defines.svh"

module motor_ctrl_board (
    input  logic                                 sysclk,
    input  logic                                 rst_n,
    input  mc_pkg::board_id_t                    board_id,
    input  logic                                 tick,
    reg_bus_if.target                            bus,
    input  mc_pkg::amp_mask_t                    enc_a,
    input  mc_pkg::amp_mask_t                    enc_b,
    output mc_pkg::dac_t [`MC_NUM_MOTORS-1:0]    dac_out,
    output mc_pkg::amp_mask_t                    amp_en
);

    localparam int NM = `MC_NUM_MOTORS;

    logic [3:0]           wchan;            // Write channel field
    logic [3:0]           wreg;             // Write register field
    logic [3:0]           rchan;
    logic [3:0]           rreg;
    logic                 board_wr;         // Write to channel 0
    logic                 wdog_clear;
    logic                 wdog_timeout;
    mc_pkg::wdog_period_t wdog_period;
    mc_pkg::reg_data_t    status_word;
    mc_pkg::reg_data_t    rd_next;
    mc_pkg::enc_count_t   enc_count [NM];

    assign wchan = bus.waddr[7:4];
    assign wreg  = bus.waddr[3:0];
    assign rchan = bus.raddr[7:4];
    assign rreg  = bus.raddr[3:0];

    assign board_wr   = bus.wen && (wchan == 4'd0);
    assign wdog_clear = board_wr && (wreg == `MC_REG_STATUS) && bus.wdata[8];   // Bit 8 clears

    // Channel count [15:12], timeout [8], board id [3:0]
    assign status_word = {16'd0, 4'(NM), 3'd0, wdog_timeout, 4'd0, board_id};

    // Board channel registers
    always_ff @(posedge sysclk or negedge rst_n) begin
        if (!rst_n) begin
            wdog_period <= '0;      // Watchdog off
            amp_en      <= '0;
        end else begin
            if (board_wr && (wreg == `MC_REG_WDOG_PERIOD)) begin
                wdog_period <= bus.wdata[15:0];
            end
            // Timeout drops every amplifier, host must re-enable after clear
            if (wdog_timeout) begin
                amp_en <= '0;
            end else if (board_wr && (wreg == `MC_REG_AMP_EN)) begin
                amp_en <= bus.wdata[NM-1:0];
            end
        end
    end

    // Setpoints, motor i sits on channel i+1
    always_ff @(posedge sysclk or negedge rst_n) begin
        if (!rst_n) begin
            dac_out <= '0;
        end else begin
            for (int i = 0; i < NM; i++) begin
                if (bus.wen && (wchan == 4'(i + 1)) && (wreg == `MC_REG_DAC)) begin
                    dac_out[i] <= bus.wdata[`MC_DAC_WIDTH-1:0];
                end
            end
        end
    end

    for (genvar i = 0; i < NM; i++) begin : g_enc
        quad_encoder u_enc (
            .sysclk     (sysclk),
            .rst_n      (rst_n),
            .enc_a      (enc_a[i]),
            .enc_b      (enc_b[i]),
            .preset_en  (bus.wen && (wchan == 4'(i + 1)) && (wreg == `MC_REG_ENC)),
            .preset_val (bus.wdata[`MC_ENC_WIDTH-1:0]),
            .count      (enc_count[i])
        );
    end

    motor_wdog u_wdog (
        .sysclk     (sysclk),
        .rst_n      (rst_n),
        .tick       (tick),
        .host_write (bus.wen),        // Any bus write is host activity
        .period     (wdog_period),
        .clear      (wdog_clear),
        .timeout    (wdog_timeout)
    );

    // Read mux, unmapped addresses return zero
    always_comb begin
        rd_next = '0;
        if (rchan == 4'd0) begin
            case (rreg)
                `MC_REG_STATUS:      rd_next = status_word;
                `MC_REG_WDOG_PERIOD: rd_next = 32'(wdog_period);
                `MC_REG_AMP_EN:      rd_next = 32'(amp_en);
                default:             rd_next = '0;
            endcase
        end
        for (int i = 0; i < NM; i++) begin
            if (rchan == 4'(i + 1)) begin
                if (rreg == `MC_REG_DAC) begin
                    rd_next = 32'(dac_out[i]);
                end else if (rreg == `MC_REG_ENC) begin
                    rd_next = {{(32 - `MC_ENC_WIDTH){enc_count[i][`MC_ENC_WIDTH-1]}},
                               enc_count[i]};     // Sign extended
                end
            end
        end
    end

    // Read data one cycle after raddr
    always_ff @(posedge sysclk) begin
        bus.rdata <= rd_next;
    end

endmodule

// ==== source/mc_top.sv ====
// Motor controller subsystem top
// APB host side, watchdog time base and the board register block
`timescale 1ns/1ps
`include "mc_defines.svh"

module mc_top (
    input  logic                                 sysclk,
    input  logic                                 rst_n,
    input  mc_pkg::board_id_t                    board_id,
    input  logic                                 psel,
    input  logic                                 penable,
    input  logic                                 pwrite,
    input  mc_pkg::reg_addr_t                    paddr,
    input  mc_pkg::reg_data_t                    pwdata,
    output mc_pkg::reg_data_t                    prdata,
    output logic                                 pready,
    output logic                                 pslverr,
    input  mc_pkg::amp_mask_t                    enc_a,
    input  mc_pkg::amp_mask_t                    enc_b,
    output mc_pkg::dac_t [`MC_NUM_MOTORS-1:0]    dac_out,
    output mc_pkg::amp_mask_t                    amp_en
);

    logic wdog_tick;        // Watchdog time base enable

    reg_bus_if reg_bus ();  // Bridge to board block

    apb_reg_bridge u_bridge (
        .sysclk  (sysclk),
        .rst_n   (rst_n),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr),
        .bus     (reg_bus.master)
    );

    tick_gen u_tick (
        .sysclk (sysclk),
        .rst_n  (rst_n),
        .tick   (wdog_tick)
    );

    motor_ctrl_board u_board (
        .sysclk   (sysclk),
        .rst_n    (rst_n),
        .board_id (board_id),
        .tick     (wdog_tick),
        .bus      (reg_bus.target),
        .enc_a    (enc_a),
        .enc_b    (enc_b),
        .dac_out  (dac_out),
        .amp_en   (amp_en)
    );

endmodule

// ==== dv/tb_mc_top.sv ====
// Testbench for the motor controller subsystem
// Directed APB tests of setpoints, encoders and the host watchdog
`timescale 1ns/1ps
`include "mc_defines.svh"

module tb_mc_top;

    localparam int         NM         = `MC_NUM_MOTORS;
    localparam int         CLK_HALF   = 10;      // 20 ns period
    localparam int         DRV_DLY    = 2;       // Input skew after the rising edge
    localparam int         MAX_CYCLES = 4000;    // All tests need well under 1500
    localparam logic [3:0] BOARD_ID   = 4'hA;

    logic                  sysclk;
    logic                  rst_n;
    mc_pkg::board_id_t     board_id;
    logic                  psel;
    logic                  penable;
    logic                  pwrite;
    mc_pkg::reg_addr_t     paddr;
    mc_pkg::reg_data_t     pwdata;
    mc_pkg::reg_data_t     prdata;
    logic                  pready;
    logic                  pslverr;
    mc_pkg::amp_mask_t     enc_a;
    mc_pkg::amp_mask_t     enc_b;
    mc_pkg::dac_t [NM-1:0] dac_out;
    mc_pkg::amp_mask_t     amp_en;

    logic [31:0] lfsr_state;   // Random source for setpoints and presets
    int          enc_phase;    // Position in the Gray cycle 00 10 11 01

    mc_top dut (
        .sysclk  (sysclk),
        .rst_n   (rst_n),
        .board_id(board_id),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr),
        .enc_a   (enc_a),
        .enc_b   (enc_b),
        .dac_out (dac_out),
        .amp_en  (amp_en)
    );

    initial begin
        sysclk = 1'b0;
        forever #CLK_HALF sysclk = ~sysclk;
    end

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Simulation failed");
        $fatal(1, "run stopped");
    endtask

    // Ends a run that stalls on a missing handshake
    initial begin : run_limit
        repeat (MAX_CYCLES) @(posedge sysclk);
        fail_run($sformatf("Timeout: tests still running after %0d cycles", MAX_CYCLES));
    end

    // Galois form, taps x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h8020_0003;
        end else begin
            return s >> 1;
        end
    endfunction

    function automatic mc_pkg::reg_data_t rand_bits(input int n);
        mc_pkg::reg_data_t r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);   // One step per bit
            r[i] = lfsr_state[0];
        end
        return r;
    endfunction

    function automatic mc_pkg::reg_addr_t reg_addr(input int chan, input logic [3:0] r);
        return {8'd0, 4'(chan), r};               // [7:4] channel, [3:0] register
    endfunction

    // Channel count [15:12], timeout [8], board id [3:0]
    function automatic mc_pkg::reg_data_t status_expected(input logic timed_out);
        mc_pkg::reg_data_t s;
        s = '0;
        s[3:0]   = BOARD_ID;
        s[8]     = timed_out;
        s[15:12] = 4'(NM);
        return s;
    endfunction

    // Count value as a 32-bit two's complement word
    function automatic mc_pkg::reg_data_t enc_word(input mc_pkg::enc_count_t e);
        mc_pkg::reg_data_t w;
        w = 32'(e);
        if (e[`MC_ENC_WIDTH-1]) begin
            w = w - (32'd1 << `MC_ENC_WIDTH);     // Negative count, value minus 2^N
        end
        return w;
    endfunction

    task automatic check_data(input string name, input mc_pkg::reg_data_t got,
                              input mc_pkg::reg_data_t exp);
        if (got !== exp) begin
            fail_run($sformatf("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp));
        end
    endtask

    task automatic check_dac(input string name, input mc_pkg::dac_t got,
                             input mc_pkg::dac_t exp);
        if (got !== exp) begin
            fail_run($sformatf("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp));
        end
    endtask

    task automatic check_amp(input string name, input mc_pkg::amp_mask_t got,
                             input mc_pkg::amp_mask_t exp);
        if (got !== exp) begin
            fail_run($sformatf("Mismatch at %0t: %s got %b expected %b", $time, name, got, exp));
        end
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) @(posedge sysclk);
        #DRV_DLY;                                 // Stay aligned for driving
    endtask

    // Sampled at the falling edge, away from the update edge
    task automatic wait_pready(input int exp_waits);
        int waits;
        waits = 0;
        @(negedge sysclk);
        while (pready !== 1'b1) begin
            waits++;
            if (waits > 8) fail_run("APB slave never raised pready");
            @(negedge sysclk);
        end
        if (waits != exp_waits) begin
            fail_run($sformatf("APB transfer took %0d wait states instead of %0d",
                               waits, exp_waits));
        end
        if (pslverr !== 1'b0) fail_run("APB slave flagged an error on a transfer");
    endtask

    task automatic apb_write(input mc_pkg::reg_addr_t addr, input mc_pkg::reg_data_t data);
        @(posedge sysclk);
        #DRV_DLY;
        psel    = 1'b1;                           // Setup phase
        penable = 1'b0;
        pwrite  = 1'b1;
        paddr   = addr;
        pwdata  = data;
        @(posedge sysclk);
        #DRV_DLY;
        penable = 1'b1;                           // Access phase
        wait_pready(0);
        @(posedge sysclk);
        #DRV_DLY;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_read(input mc_pkg::reg_addr_t addr, output mc_pkg::reg_data_t data);
        @(posedge sysclk);
        #DRV_DLY;
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = addr;
        @(posedge sysclk);
        #DRV_DLY;
        penable = 1'b1;
        wait_pready(1);                           // One wait state on reads
        data = prdata;
        @(posedge sysclk);
        #DRV_DLY;
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    // One quadrature step on motor m, held 4 cycles
    task automatic encoder_step(input int m, input int dir);
        enc_phase = (enc_phase + dir + 4) % 4;
        case (enc_phase)
            0:       {enc_a[m], enc_b[m]} = 2'b00;
            1:       {enc_a[m], enc_b[m]} = 2'b10;   // A leads B going forward
            2:       {enc_a[m], enc_b[m]} = 2'b11;
            default: {enc_a[m], enc_b[m]} = 2'b01;
        endcase
        idle_cycles(4);
    endtask

    task automatic reset_values();
        mc_pkg::reg_data_t rd;
        apb_read(reg_addr(0, `MC_REG_STATUS), rd);
        check_data("status", rd, status_expected(1'b0));
        for (int i = 0; i < NM; i++) begin
            check_dac($sformatf("dac_out[%0d]", i), dac_out[i], '0);
        end
        check_amp("amp_en", amp_en, '0);
    endtask

    task automatic setpoint_path();
        mc_pkg::dac_t      sp [NM];
        mc_pkg::reg_data_t r;
        mc_pkg::amp_mask_t mask;
        for (int i = 0; i < NM; i++) begin
            r = rand_bits(`MC_DAC_WIDTH);
            sp[i] = r[`MC_DAC_WIDTH-1:0];
            apb_write(reg_addr(i + 1, `MC_REG_DAC), r);
            check_dac($sformatf("dac_out[%0d]", i), dac_out[i], sp[i]);
        end
        for (int i = 0; i < NM; i++) begin
            check_dac($sformatf("dac_out[%0d]", i), dac_out[i], sp[i]);   // No cross talk
            apb_read(reg_addr(i + 1, `MC_REG_DAC), r);
            check_data($sformatf("dac reg %0d", i + 1), r, 32'(sp[i]));
        end
        r = rand_bits(NM);
        mask = r[NM-1:0];
        apb_write(reg_addr(0, `MC_REG_AMP_EN), 32'(mask));
        check_amp("amp_en", amp_en, mask);
        apb_read(reg_addr(0, `MC_REG_AMP_EN), r);
        check_data("amp_en reg", r, 32'(mask));
    endtask

    task automatic encoder_counting(input int m);
        mc_pkg::reg_data_t  r;
        mc_pkg::enc_count_t exp;
        r = rand_bits(`MC_ENC_WIDTH);
        exp = r[`MC_ENC_WIDTH-1:0];
        apb_write(reg_addr(m + 1, `MC_REG_ENC), r);          // Preset
        apb_read(reg_addr(m + 1, `MC_REG_ENC), r);
        check_data("enc preset", r, enc_word(exp));
        for (int s = 0; s < 10; s++) encoder_step(m, 1);
        exp = exp + mc_pkg::enc_count_t'(10);
        idle_cycles(5);                                       // Sync plus count update
        apb_read(reg_addr(m + 1, `MC_REG_ENC), r);
        check_data("enc forward", r, enc_word(exp));
        for (int s = 0; s < 7; s++) encoder_step(m, -1);
        exp = exp - mc_pkg::enc_count_t'(7);
        idle_cycles(5);
        apb_read(reg_addr(m + 1, `MC_REG_ENC), r);
        check_data("enc reverse", r, enc_word(exp));
    endtask

    task automatic host_timeout();
        mc_pkg::reg_data_t rd;
        apb_write(reg_addr(0, `MC_REG_AMP_EN), 32'hF);
        check_amp("amp_en", amp_en, 4'hF);
        apb_write(reg_addr(0, `MC_REG_WDOG_PERIOD), 32'd5);
        idle_cycles(5 * `MC_WDOG_TICK_DIV + 8);               // Silent host
        check_amp("amp_en after timeout", amp_en, '0);
        apb_read(reg_addr(0, `MC_REG_STATUS), rd);
        check_data("status after timeout", rd, status_expected(1'b1));
        apb_write(reg_addr(0, `MC_REG_STATUS), 32'h100);     // Bit 8 clears
        apb_read(reg_addr(0, `MC_REG_STATUS), rd);
        check_data("status after clear", rd, status_expected(1'b0));
        idle_cycles(3);
        check_amp("amp_en after clear", amp_en, '0);          // Stays off until rewritten
        apb_write(reg_addr(0, `MC_REG_AMP_EN), 32'h6);
        check_amp("amp_en rewritten", amp_en, 4'h6);
        apb_write(reg_addr(0, `MC_REG_WDOG_PERIOD), 32'd0);  // Watchdog off again
    endtask

    task automatic host_keepalive();
        mc_pkg::reg_data_t r;
        mc_pkg::amp_mask_t mask;
        r = rand_bits(NM);
        mask = r[NM-1:0] | 4'b0001;               // Nonzero so a trip would show
        apb_write(reg_addr(0, `MC_REG_WDOG_PERIOD), 32'd5);
        apb_write(reg_addr(0, `MC_REG_AMP_EN), 32'(mask));
        for (int k = 0; k < 10; k++) begin
            idle_cycles(17);                      // Writes 20 cycles apart
            check_amp("amp_en kept alive", amp_en, mask);
            apb_write(reg_addr(0, `MC_REG_WDOG_PERIOD), 32'd5);
        end
        apb_read(reg_addr(0, `MC_REG_STATUS), r);
        check_data("status kept alive", r, status_expected(1'b0));
    endtask

    initial begin
        lfsr_state = 32'h1272;
        enc_phase  = 0;
        rst_n      = 1'b0;
        board_id   = BOARD_ID;
        psel       = 1'b0;
        penable    = 1'b0;
        pwrite     = 1'b0;
        paddr      = '0;
        pwdata     = '0;
        enc_a      = '0;
        enc_b      = '0;
        repeat (2) @(posedge sysclk);
        #DRV_DLY;
        rst_n = 1'b1;
        reset_values();
        setpoint_path();
        encoder_counting(1);                      // Motor 2, channel 2
        host_timeout();
        host_keepalive();
        $display("Simulation completed successfully");
        $finish;
    end

endmodule

// ==== tb.f ====
+incdir+source
source/mc_pkg.sv
source/reg_bus_if.sv
source/apb_reg_bridge.sv
source/tick_gen.sv
source/quad_encoder.sv
source/motor_wdog.sv
source/motor_ctrl_board.sv
source/mc_top.sv
dv/tb_mc_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the motor controller testbench with Verilator
cd "$(dirname "$0")" &&
verilator --binary --timing -Wno-fatal --top-module tb_mc_top -f tb.f -o tb_mc_top &&
./obj_dir/tb_mc_top || exit 1
